// ==== src/dbg_pkg.sv ====
`default_nettype none

package dbg_pkg;

  // watched accelerator stages.
  localparam int NUM_STAGES = 4;
  localparam int STG_SPMM   = 0;
  localparam int STG_DMVM   = 1;
  localparam int STG_SM     = 2;
  localparam int STG_AGGR   = 3;

  localparam int ADDR_W    = 14;
  localparam int PE_DATA_W = 12;
  localparam int CNT_W     = 20;

  // bit 31 of every record.
  localparam logic REC_TAG_CAPTURE = 1'b0;
  localparam logic REC_TAG_STATUS  = 1'b1;

  typedef struct packed {
    logic                 tag;
    logic                 slot;
    logic [3:0]           reserved;
    logic [ADDR_W-1:0]    addr;
    logic [PE_DATA_W-1:0] data;
  } capture_rec_t;

  // flags run spmm vld/rdy in bits 7:6 down to aggr vld/rdy in bits 1:0.
  typedef struct packed {
    logic             tag;
    logic             overflow;
    logic [1:0]       reserved;
    logic [7:0]       flags;
    logic [CNT_W-1:0] count;
  } status_rec_t;

  // tag selects which view applies.
  typedef union packed {
    capture_rec_t cap;
    status_rec_t  stat;
  } trace_rec_u;

endpackage

`default_nettype wire

// ==== src/trace_if.sv ====
`timescale 1ns/1ps
`default_nettype none

interface trace_if;

  import dbg_pkg::*;

  logic       valid;
  logic       ready;
  trace_rec_u rec;

  // producer side.
  modport source (
    output valid,
    output rec,
    input  ready
  );

  // consumer side.
  modport sink (
    input  valid,
    input  rec,
    output ready
  );

endinterface

`default_nettype wire

// ==== src/stage_monitor.sv ====
`timescale 1ns/1ps
`default_nettype none

module stage_monitor #(
  parameter logic [dbg_pkg::ADDR_W-1:0] WATCH_ADDR_A = 10,
  parameter logic [dbg_pkg::ADDR_W-1:0] WATCH_ADDR_B = 20
) (
  input  wire logic                           clk,
  input  wire logic                           rst_n,
  input  wire logic [dbg_pkg::NUM_STAGES-1:0] stage_vld_i,
  input  wire logic [dbg_pkg::NUM_STAGES-1:0] stage_rdy_i,
  input  wire logic [dbg_pkg::ADDR_W-1:0]     wgt_addr_i,
  input  wire logic [dbg_pkg::PE_DATA_W-1:0]  pe_data_i,
  input  wire logic                           snapshot_req_i,
  trace_if.source                             rec_o
);

  import dbg_pkg::*;

  logic [7:0]       line_vec;
  logic [7:0]       flags_q;
  logic [7:0]       flags_cur;
  logic [CNT_W-1:0] count_q;
  logic [CNT_W-1:0] count_cur;
  logic             ovf_q;
  logic             hit_a;
  logic             hit_b;
  logic             cap_evt;
  logic             can_load;
  logic             load_stat;
  logic             load_cap;
  logic             drop_any;
  logic             rec_vld_q;
  trace_rec_u       rec_q;
  trace_rec_u       stat_rec;
  trace_rec_u       cap_rec;

  // two bits per stage, spmm in the top pair.
  always_comb begin
    for (int i = 0; i < NUM_STAGES; i++) begin
      line_vec[7-2*i] = stage_vld_i[i];
      line_vec[6-2*i] = stage_rdy_i[i];
    end
  end

  assign flags_cur = flags_q | line_vec;
  assign count_cur = (stage_vld_i[STG_SM] && (count_q != {CNT_W{1'b1}})) ?
                     count_q + 1'b1 : count_q;

  assign hit_a   = stage_rdy_i[STG_SPMM] && (wgt_addr_i == WATCH_ADDR_A);
  assign hit_b   = stage_rdy_i[STG_SPMM] && (wgt_addr_i == WATCH_ADDR_B);
  assign cap_evt = hit_a || hit_b;

  // register is free or emptied this cycle.
  assign can_load  = !rec_vld_q || rec_o.ready;
  assign load_stat = snapshot_req_i && can_load;
  assign load_cap  = cap_evt && !snapshot_req_i && can_load;
  // snapshot wins, so a same-cycle capture is lost.
  assign drop_any  = (snapshot_req_i && !can_load) || (cap_evt && !load_cap);

  always_comb begin
    stat_rec               = '0;
    stat_rec.stat.tag      = REC_TAG_STATUS;
    stat_rec.stat.overflow = ovf_q;
    stat_rec.stat.flags    = flags_cur;
    stat_rec.stat.count    = count_cur;
    cap_rec                = '0;
    cap_rec.cap.tag        = REC_TAG_CAPTURE;
    cap_rec.cap.slot       = !hit_a;
    cap_rec.cap.addr       = wgt_addr_i;
    cap_rec.cap.data       = pe_data_i;
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      flags_q <= '0;
      count_q <= '0;
      ovf_q   <= 1'b0;
    end else if (snapshot_req_i) begin
      // restart accumulation after the snapshot.
      flags_q <= '0;
      count_q <= '0;
      ovf_q   <= drop_any;
    end else begin
      flags_q <= flags_cur;
      count_q <= count_cur;
      ovf_q   <= ovf_q | drop_any;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rec_vld_q <= 1'b0;
    end else if (load_stat || load_cap) begin
      rec_vld_q <= 1'b1;
    end else if (rec_o.ready) begin
      rec_vld_q <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (load_stat) begin
      rec_q <= stat_rec;
    end else if (load_cap) begin
      rec_q <= cap_rec;
    end
  end

  assign rec_o.valid = rec_vld_q;
  assign rec_o.rec   = rec_q;

endmodule

`default_nettype wire

// ==== src/trace_fifo.sv ====
`timescale 1ns/1ps
`default_nettype none

module trace_fifo #(
  parameter int FIFO_DEPTH = 8
) (
  input  wire logic clk,
  input  wire logic rst_n,
  trace_if.sink     wr_i,
  trace_if.source   rd_o
);

  import dbg_pkg::*;

  localparam int PTR_W = $clog2(FIFO_DEPTH);
  localparam int OCC_W = $clog2(FIFO_DEPTH + 1);

  trace_rec_u       mem [FIFO_DEPTH];
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  // records held, output stage included.
  logic [OCC_W-1:0] count_q;
  logic             out_vld_q;
  trace_rec_u       out_q;
  logic             wr_en;
  logic             rd_acc;
  logic             mem_nonempty;
  logic             load_out;

  assign wr_i.ready   = (count_q != OCC_W'(FIFO_DEPTH));
  assign wr_en        = wr_i.valid && wr_i.ready;
  assign rd_acc       = out_vld_q && rd_o.ready;
  assign mem_nonempty = (count_q != {{(OCC_W-1){1'b0}}, out_vld_q});
  assign load_out     = mem_nonempty && (!out_vld_q || rd_o.ready);

  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_ptr_q] <= wr_i.rec;
    end
  end

  always_ff @(posedge clk) begin
    if (load_out) begin
      out_q <= mem[rd_ptr_q];
    end
  end

  // pointers wrap on their own since the depth is a power of two.
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr_q  <= '0;
      rd_ptr_q  <= '0;
      count_q   <= '0;
      out_vld_q <= 1'b0;
    end else begin
      if (wr_en) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (load_out) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      if (wr_en && !rd_acc) begin
        count_q <= count_q + 1'b1;
      end else if (!wr_en && rd_acc) begin
        count_q <= count_q - 1'b1;
      end
      if (load_out) begin
        out_vld_q <= 1'b1;
      end else if (rd_acc) begin
        out_vld_q <= 1'b0;
      end
    end
  end

  assign rd_o.valid = out_vld_q;
  assign rd_o.rec   = out_q;

endmodule

`default_nettype wire

// ==== src/trace_readout.sv ====
`timescale 1ns/1ps
`default_nettype none

module trace_readout (
  input  wire logic                          clk,
  input  wire logic                          rst_n,
  trace_if.sink                              rec_i,
  output logic [31:0]                        rec_data_o,
  output logic                               rec_valid_o,
  input  wire logic                          rec_ready_i,
  output logic [dbg_pkg::PE_DATA_W-1:0]      capture_a_o,
  output logic [dbg_pkg::PE_DATA_W-1:0]      capture_b_o
);

  import dbg_pkg::*;

  logic                 accept;
  logic                 is_cap;
  logic [PE_DATA_W-1:0] cap_a_q;
  logic [PE_DATA_W-1:0] cap_b_q;

  // host port is a straight pass of the FIFO head.
  assign rec_data_o  = rec_i.rec;
  assign rec_valid_o = rec_i.valid;
  assign rec_i.ready = rec_ready_i;

  assign accept = rec_i.valid && rec_ready_i;
  assign is_cap = (rec_i.rec.cap.tag == REC_TAG_CAPTURE);

  // status records leave the slots alone.
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cap_a_q <= '0;
      cap_b_q <= '0;
    end else if (accept && is_cap) begin
      if (rec_i.rec.cap.slot) begin
        cap_b_q <= rec_i.rec.cap.data;
      end else begin
        cap_a_q <= rec_i.rec.cap.data;
      end
    end
  end

  assign capture_a_o = cap_a_q;
  assign capture_b_o = cap_b_q;

endmodule

`default_nettype wire

// ==== src/gnn_debug_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module gnn_debug_top #(
  parameter logic [dbg_pkg::ADDR_W-1:0] WATCH_ADDR_A = 10,
  parameter logic [dbg_pkg::ADDR_W-1:0] WATCH_ADDR_B = 20,
  parameter int                         FIFO_DEPTH   = 8
) (
  input  wire logic                           clk,
  input  wire logic                           rst_n,
  input  wire logic [dbg_pkg::NUM_STAGES-1:0] stage_vld_i,
  input  wire logic [dbg_pkg::NUM_STAGES-1:0] stage_rdy_i,
  input  wire logic [dbg_pkg::ADDR_W-1:0]     wgt_addr_i,
  input  wire logic [dbg_pkg::PE_DATA_W-1:0]  pe_data_i,
  input  wire logic                           snapshot_req_i,
  output logic [31:0]                         rec_data_o,
  output logic                                rec_valid_o,
  input  wire logic                           rec_ready_i,
  output logic [dbg_pkg::PE_DATA_W-1:0]       capture_a_o,
  output logic [dbg_pkg::PE_DATA_W-1:0]       capture_b_o
);

  trace_if mon_to_fifo ();
  trace_if fifo_to_rd ();

  stage_monitor #(
    .WATCH_ADDR_A (WATCH_ADDR_A),
    .WATCH_ADDR_B (WATCH_ADDR_B)
  ) stage_monitor_inst (
    .clk            (clk),
    .rst_n          (rst_n),
    .stage_vld_i    (stage_vld_i),
    .stage_rdy_i    (stage_rdy_i),
    .wgt_addr_i     (wgt_addr_i),
    .pe_data_i      (pe_data_i),
    .snapshot_req_i (snapshot_req_i),
    .rec_o          (mon_to_fifo.source)
  );

  trace_fifo #(
    .FIFO_DEPTH (FIFO_DEPTH)
  ) trace_fifo_inst (
    .clk   (clk),
    .rst_n (rst_n),
    .wr_i  (mon_to_fifo.sink),
    .rd_o  (fifo_to_rd.source)
  );

  trace_readout trace_readout_inst (
    .clk         (clk),
    .rst_n       (rst_n),
    .rec_i       (fifo_to_rd.sink),
    .rec_data_o  (rec_data_o),
    .rec_valid_o (rec_valid_o),
    .rec_ready_i (rec_ready_i),
    .capture_a_o (capture_a_o),
    .capture_b_o (capture_b_o)
  );

endmodule

`default_nettype wire

// ==== dv/gnn_debug_asserts.sv ====
`timescale 1ns/1ps
`default_nettype none

module gnn_debug_asserts #(
  parameter int DEPTH = 8
) (
  input wire logic        clk,
  input wire logic        rst_n,
  input wire logic        wr_valid,
  input wire logic        wr_ready,
  input wire logic [31:0] wr_rec,
  input wire logic        rd_valid,
  input wire logic        rd_ready,
  input wire logic [31:0] rd_rec
);

  logic [$clog2(DEPTH+1)-1:0] occ_q;
  logic                       wr_xfer;
  logic                       rd_xfer;
  int                         fail_count = 0;

  assign wr_xfer = wr_valid && wr_ready;
  assign rd_xfer = rd_valid && rd_ready;

  // records held, counted from the link transfers.
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      occ_q <= '0;
    end else if (wr_xfer && !rd_xfer) begin
      occ_q <= occ_q + 1'b1;
    end else if (!wr_xfer && rd_xfer) begin
      occ_q <= occ_q - 1'b1;
    end
  end

  // stalled records hold still on both links.
  wr_stable_a: assert property (@(posedge clk) disable iff (!rst_n)
    wr_valid && !wr_ready |=> $stable(wr_rec))
    else begin
      $error("monitor record changed while stalled");
      fail_count++;
    end

  rd_stable_a: assert property (@(posedge clk) disable iff (!rst_n)
    rd_valid && !rd_ready |=> $stable(rd_rec))
    else begin
      $error("fifo output record changed while stalled");
      fail_count++;
    end

  wr_hold_a: assert property (@(posedge clk) disable iff (!rst_n)
    wr_valid && !wr_ready |=> wr_valid)
    else begin
      $error("monitor valid dropped without a transfer");
      fail_count++;
    end

  rd_hold_a: assert property (@(posedge clk) disable iff (!rst_n)
    rd_valid && !rd_ready |=> rd_valid)
    else begin
      $error("fifo valid dropped without a transfer");
      fail_count++;
    end

  full_a: assert property (@(posedge clk) disable iff (!rst_n)
    (occ_q == DEPTH) |-> !wr_xfer)
    else begin
      $error("write accepted into a full fifo");
      fail_count++;
    end

endmodule

bind trace_fifo gnn_debug_asserts #(
  .DEPTH (FIFO_DEPTH)
) fifo_asserts_inst (
  .clk      (clk),
  .rst_n    (rst_n),
  .wr_valid (wr_i.valid),
  .wr_ready (wr_i.ready),
  .wr_rec   (wr_i.rec),
  .rd_valid (rd_o.valid),
  .rd_ready (rd_o.ready),
  .rd_rec   (rd_o.rec)
);

`default_nettype wire

// ==== dv/gnn_debug_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module gnn_debug_tb;

  import dbg_pkg::*;

  localparam int WATCH_A    = 10;
  localparam int WATCH_B    = 20;
  localparam int FIFO_DEPTH = 8;
  localparam int DRAIN_MAX  = 200;

  // rmode 0 holds the host off, 1 accepts, 2 draws from the generator.
  typedef struct packed {
    logic [3:0]           vld;
    logic [3:0]           rdy;
    logic [ADDR_W-1:0]    addr;
    logic [PE_DATA_W-1:0] data;
    logic                 snap;
    logic [1:0]           rmode;
  } step_t;

  logic                 clk;
  logic                 rst_n;
  logic [3:0]           stage_vld;
  logic [3:0]           stage_rdy;
  logic [ADDR_W-1:0]    wgt_addr;
  logic [PE_DATA_W-1:0] pe_data;
  logic                 snap_req;
  logic                 rec_ready;
  logic [31:0]          rec_data;
  logic                 rec_valid;
  logic [PE_DATA_W-1:0] capture_a;
  logic [PE_DATA_W-1:0] capture_b;

  step_t       steps[$];
  int          test_end[$];
  int          test_exp[$];
  string       test_name[$];
  logic [31:0] exp_q[$];
  logic [31:0] rng;
  int          checks;
  int          errors;
  int          received;

  // reference model state.
  logic [7:0]           m_flags;
  logic [CNT_W-1:0]     m_cnt;
  logic                 m_ovf;
  logic                 m_reg_vld;
  int                   m_fcnt;
  logic                 m_out_vld;
  logic [PE_DATA_W-1:0] m_cap_a;
  logic [PE_DATA_W-1:0] m_cap_b;

  gnn_debug_top #(
    .WATCH_ADDR_A (WATCH_A),
    .WATCH_ADDR_B (WATCH_B),
    .FIFO_DEPTH   (FIFO_DEPTH)
  ) gnn_debug_top_inst (
    .clk            (clk),
    .rst_n          (rst_n),
    .stage_vld_i    (stage_vld),
    .stage_rdy_i    (stage_rdy),
    .wgt_addr_i     (wgt_addr),
    .pe_data_i      (pe_data),
    .snapshot_req_i (snap_req),
    .rec_data_o     (rec_data),
    .rec_valid_o    (rec_valid),
    .rec_ready_i    (rec_ready),
    .capture_a_o    (capture_a),
    .capture_b_o    (capture_b)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic step_t make_step(input logic [3:0] vld, input logic [3:0] rdy,
                                      input int addr, input int data, input logic snap,
                                      input logic [1:0] rmode);
    step_t st;
    st.vld   = vld;
    st.rdy   = rdy;
    st.addr  = ADDR_W'(addr);
    st.data  = PE_DATA_W'(data);
    st.snap  = snap;
    st.rmode = rmode;
    return st;
  endfunction

  task automatic close_test(input string name, input int exp_recs);
    test_name.push_back(name);
    test_exp.push_back(exp_recs);
    test_end.push_back(steps.size());
  endtask

  task automatic build_tests();
    logic [2:0] sel;
    int         addr;
    steps.push_back(make_step(4'b0001, 4'b0000, 0, 0, 1'b0, 2'd1));
    steps.push_back(make_step(4'b0000, 4'b0100, 0, 0, 1'b0, 2'd1));
    steps.push_back(make_step(4'b1000, 4'b0000, 0, 0, 1'b0, 2'd1));
    steps.push_back(make_step(4'b0000, 4'b0010, 0, 0, 1'b0, 2'd1));
    steps.push_back(make_step(4'b0000, 4'b0000, 0, 0, 1'b1, 2'd1));
    steps.push_back(make_step(4'b0000, 4'b0000, 0, 0, 1'b1, 2'd1));
    close_test("sticky flags", 2);
    // five softmax beats with gaps.
    for (int i = 0; i < 9; i++) begin
      steps.push_back(make_step((i % 2 == 0) ? 4'b0100 : 4'b0000, 4'b0000, 0, 0, 1'b0, 2'd1));
    end
    steps.push_back(make_step(4'b0000, 4'b0000, 0, 0, 1'b1, 2'd1));
    close_test("beat count", 1);
    steps.push_back(make_step(4'b0000, 4'b0001, WATCH_A, 'h123, 1'b0, 2'd1));
    steps.push_back(make_step(4'b0000, 4'b0001, WATCH_B, 'h456, 1'b0, 2'd1));
    steps.push_back(make_step(4'b0000, 4'b0000, WATCH_A, 'h9ab, 1'b0, 2'd1));
    steps.push_back(make_step(4'b0000, 4'b0001, 11, 'h9ac, 1'b0, 2'd1));
    steps.push_back(make_step(4'b0000, 4'b0010, WATCH_B, 'h9ad, 1'b0, 2'd1));
    steps.push_back(make_step(4'b0000, 4'b0001, WATCH_B, 'h789, 1'b0, 2'd1));
    close_test("watch capture", 3);
    steps.push_back(make_step(4'b0000, 4'b0001, WATCH_A, 'h321, 1'b1, 2'd1));
    steps.push_back(make_step(4'b0000, 4'b0000, 0, 0, 1'b1, 2'd1));
    close_test("priority", 2);
    for (int i = 0; i < FIFO_DEPTH + 4; i++) begin
      addr = (i % 2 == 0) ? WATCH_A : WATCH_B;
      steps.push_back(make_step(4'b0000, 4'b0001, addr, 'h500 + i, 1'b0, 2'd0));
    end
    for (int i = 0; i < 3; i++) begin
      steps.push_back(make_step(4'b0000, 4'b0000, 0, 0, 1'b0, 2'd1));
    end
    steps.push_back(make_step(4'b0000, 4'b0000, 0, 0, 1'b1, 2'd1));
    close_test("back-pressure", FIFO_DEPTH + 2);
    for (int i = 0; i < 60; i++) begin
      rng  = xorshift32(rng);
      sel  = rng[2:0];
      addr = (sel == 3'd0) ? WATCH_A : (sel == 3'd1) ? WATCH_B : int'(rng[23:16]);
      steps.push_back(make_step(rng[7:4], {rng[11:9], sel < 3'd2}, addr, int'(rng[31:20]),
                                sel == 3'd2, 2'd2));
    end
    steps.push_back(make_step(4'b0000, 4'b0000, 0, 0, 1'b1, 2'd2));
    close_test("random stalls", -1);
  endtask

  task automatic apply_step(input step_t st);
    stage_vld <= st.vld;
    stage_rdy <= st.rdy;
    wgt_addr  <= st.addr;
    pe_data   <= st.data;
    snap_req  <= st.snap;
    if (st.rmode == 2'd2) begin
      rng = xorshift32(rng);
      rec_ready <= rng[0];
    end else begin
      rec_ready <= st.rmode[0];
    end
  endtask

  task automatic check_value(input string name, input logic [31:0] exp_v,
                             input logic [31:0] got_v);
    checks++;
    assert (got_v == exp_v) else begin
      $display("[ERROR] %0t %s: expected %h, got %h", $time, name, exp_v, got_v);
      errors++;
    end
  endtask

  // a record leaves at the next edge when valid and ready are both up.
  task automatic check_output();
    check_value("rec_valid_o", 32'(m_out_vld), 32'(rec_valid));
    if (rec_valid && rec_ready) begin
      if (exp_q.size() == 0) begin
        $display("record %h left the DUT while none was expected", rec_data);
        errors++;
      end else begin
        check_value("rec_data_o", exp_q[0], rec_data);
        if (!exp_q[0][31] && exp_q[0][30]) begin
          m_cap_b = exp_q[0][PE_DATA_W-1:0];
        end else if (!exp_q[0][31]) begin
          m_cap_a = exp_q[0][PE_DATA_W-1:0];
        end
        void'(exp_q.pop_front());
        received++;
      end
    end
  endtask

  // predicts the next edge from the inputs now applied.
  task automatic model_step();
    logic [7:0]       flags;
    logic [CNT_W-1:0] cnt;
    logic             fifo_rdy;
    logic             host_acc;
    logic             can_load;
    logic             cap;
    logic             load;
    logic             drop;
    logic             load_out;
    flags    = m_flags | {stage_vld[0], stage_rdy[0], stage_vld[1], stage_rdy[1],
                          stage_vld[2], stage_rdy[2], stage_vld[3], stage_rdy[3]};
    cnt      = (stage_vld[STG_SM] && m_cnt != '1) ? m_cnt + 1'b1 : m_cnt;
    fifo_rdy = (m_fcnt != FIFO_DEPTH);
    host_acc = m_out_vld && rec_ready;
    can_load = !m_reg_vld || fifo_rdy;
    cap      = stage_rdy[STG_SPMM] && (wgt_addr == WATCH_A || wgt_addr == WATCH_B);
    load     = can_load && (snap_req || cap);
    drop     = ((snap_req || cap) && !can_load) || (snap_req && cap);
    if (load && snap_req) begin
      exp_q.push_back({1'b1, m_ovf, 2'b00, flags, cnt});
    end else if (load) begin
      exp_q.push_back({1'b0, wgt_addr == WATCH_B, 4'b0000, wgt_addr, pe_data});
    end
    if (snap_req) begin
      m_flags = '0;
      m_cnt   = '0;
      m_ovf   = drop;
    end else begin
      m_flags = flags;
      m_cnt   = cnt;
      m_ovf   = m_ovf | drop;
    end
    // fifo head shows up one edge after its write.
    load_out  = (m_fcnt > int'(m_out_vld)) && (!m_out_vld || rec_ready);
    m_fcnt    = m_fcnt + int'(m_reg_vld && fifo_rdy) - int'(host_acc);
    m_out_vld = load_out || (m_out_vld && !host_acc);
    m_reg_vld = load || (m_reg_vld && !fifo_rdy);
  endtask

  always @(negedge clk) begin
    if (rst_n) begin
      check_output();
      model_step();
    end
  end

  initial begin
    int first;
    int err0;
    int got0;
    int waited;
    rst_n     = 1'b0;
    stage_vld = '0;
    stage_rdy = '0;
    wgt_addr  = '0;
    pe_data   = '0;
    snap_req  = 1'b0;
    rec_ready = 1'b0;
    m_flags   = '0;
    m_cnt     = '0;
    m_ovf     = 1'b0;
    m_reg_vld = 1'b0;
    m_fcnt    = 0;
    m_out_vld = 1'b0;
    m_cap_a   = '0;
    m_cap_b   = '0;
    checks    = 0;
    errors    = 0;
    received  = 0;
    rng       = 32'h367203bf;
    build_tests();
    repeat (8) @(posedge clk);
    rst_n <= 1'b1;
    first = 0;
    for (int t = 0; t < test_name.size(); t++) begin
      err0 = errors;
      got0 = received;
      for (int s = first; s < test_end[t]; s++) begin
        @(posedge clk);
        apply_step(steps[s]);
      end
      first = test_end[t];
      @(posedge clk);
      apply_step(make_step(4'b0000, 4'b0000, 0, 0, 1'b0, 2'd1));
      waited = 0;
      while (exp_q.size() != 0 && waited < DRAIN_MAX) begin
        @(posedge clk);
        waited++;
      end
      if (exp_q.size() != 0) begin
        $display("timeout in test %0d, %0d expected records never left the DUT",
                 t + 1, exp_q.size());
        errors++;
        exp_q.delete();
      end
      @(negedge clk);
      check_value("capture_a_o", 32'(m_cap_a), 32'(capture_a));
      check_value("capture_b_o", 32'(m_cap_b), 32'(capture_b));
      if (test_exp[t] >= 0) begin
        check_value("record count", test_exp[t], received - got0);
      end
      $display("test %0d %s: %0d records, %0d errors", t + 1, test_name[t],
               received - got0, errors - err0);
    end
    // handshake checks bound to the fifo.
    errors += gnn_debug_top_inst.trace_fifo_inst.fifo_asserts_inst.fail_count;
    $display("%0d tests, %0d checks, %0d errors", test_name.size(), checks, errors);
    if (errors == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== filelist.f ====
src/dbg_pkg.sv
src/trace_if.sv
src/stage_monitor.sv
src/trace_fifo.sv
src/trace_readout.sv
src/gnn_debug_top.sv
dv/gnn_debug_asserts.sv
dv/gnn_debug_tb.sv

// ==== Bender.yml ====
package:
  name: gnn_debug

sources:
  - files:
      - src/dbg_pkg.sv
      - src/trace_if.sv
      - src/stage_monitor.sv
      - src/trace_fifo.sv
      - src/trace_readout.sv
      - src/gnn_debug_top.sv
  - target: test
    files:
      - dv/gnn_debug_asserts.sv
      - dv/gnn_debug_tb.sv
